//--- Makefile
VERILATOR ?= verilator
TOP       ?= com_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 52292
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "result: fail"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "result: no pass line"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- com_cs.sv
`timescale 1ns/1ps

module com_cs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fs_send,
    output logic                  fd_send,
    output logic                  fs_read,
    input  logic                  fd_read,
    output logic                  fs_com_send,
    input  logic                  fd_com_send,
    input  logic                  fs_com_read,
    output logic                  fd_com_read,
    output com_proto_pkg::btype_t com_tx_btype,
    input  com_proto_pkg::btype_t com_rx_btype,
    output com_proto_pkg::idx_t   data_idx,
    output com_proto_pkg::btype_t com_btype
);

    com_ctrl_pkg::cs_state_t state;
    com_ctrl_pkg::cs_state_t next_state;

    logic [31:0] time_cnt;
    logic [7:0]  num_cnt;
    logic        last_out;
    logic        time_up;
    logic        send_start;
    logic        read_start;
    logic        reply;

    assign last_out = (num_cnt >= com_ctrl_pkg::NUM_OUT - 8'd1);   // no wait after it.
    assign time_up = (time_cnt >= com_ctrl_pkg::TIMEOUT - 32'd1);

    // peer request wins over a user send.
    assign read_start = (state == com_ctrl_pkg::MAIN_WAIT) && fs_com_read;
    assign send_start = (state == com_ctrl_pkg::MAIN_WAIT) && fs_send && !fs_com_read;
    assign reply = (state == com_ctrl_pkg::SEND_WAIT) && !last_out && !time_up && fs_com_read;

    assign fd_send = (state == com_ctrl_pkg::SEND_DONE);
    assign fs_read = (state == com_ctrl_pkg::READ_WAIT);
    assign fs_com_send = (state == com_ctrl_pkg::READ_DONE) || (state == com_ctrl_pkg::SEND_IDLE);
    assign fd_com_read = (state == com_ctrl_pkg::READ_WORK) || (state == com_ctrl_pkg::SEND_WORK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= com_ctrl_pkg::MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            com_ctrl_pkg::MAIN_IDLE: next_state = com_ctrl_pkg::MAIN_WAIT;
            com_ctrl_pkg::MAIN_WAIT: begin
                if (read_start) begin
                    next_state = com_ctrl_pkg::READ_IDLE;
                end else if (send_start) begin
                    next_state = com_ctrl_pkg::SEND_IDLE;
                end
            end
            com_ctrl_pkg::READ_IDLE: next_state = com_ctrl_pkg::READ_WAIT;
            com_ctrl_pkg::READ_WAIT: begin
                if (fd_read) next_state = com_ctrl_pkg::READ_WORK;
            end
            com_ctrl_pkg::READ_WORK: begin
                if (!fs_com_read) next_state = com_ctrl_pkg::READ_DONE;
            end
            com_ctrl_pkg::READ_DONE: begin
                if (fd_com_send) next_state = com_ctrl_pkg::MAIN_WAIT;   // info frame out.
            end
            com_ctrl_pkg::SEND_IDLE: begin
                if (fd_com_send) next_state = com_ctrl_pkg::SEND_WAIT;
            end
            com_ctrl_pkg::SEND_WAIT: begin
                if (last_out) begin
                    next_state = com_ctrl_pkg::SEND_DONE;
                end else if (time_up) begin
                    next_state = com_ctrl_pkg::SEND_IDLE;   // resend.
                end else if (reply) begin
                    next_state = com_ctrl_pkg::SEND_WORK;
                end
            end
            com_ctrl_pkg::SEND_WORK: begin
                if (!fs_com_read) next_state = com_ctrl_pkg::SEND_DONE;
            end
            com_ctrl_pkg::SEND_DONE: begin
                if (!fs_send) next_state = com_ctrl_pkg::MAIN_IDLE;
            end
            default: next_state = com_ctrl_pkg::MAIN_IDLE;
        endcase
    end

    // frames already timed out in this attempt.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num_cnt <= 8'h00;
        end else if (state == com_ctrl_pkg::MAIN_IDLE || state == com_ctrl_pkg::SEND_DONE) begin
            num_cnt <= 8'h00;
        end else if (send_start) begin
            num_cnt <= 8'h00;
        end else if (state == com_ctrl_pkg::SEND_WAIT && time_up) begin
            num_cnt <= num_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            time_cnt <= 32'd0;
        end else if (state == com_ctrl_pkg::SEND_WAIT) begin
            time_cnt <= time_cnt + 32'd1;
        end else begin
            time_cnt <= 32'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_idx <= com_ctrl_pkg::DATA_IDX - 4'd1;   // first send uses the top index.
        end else if (send_start) begin
            if (data_idx == com_ctrl_pkg::DATA_IDX) begin
                data_idx <= 4'd0;
            end else begin
                data_idx <= data_idx + 4'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com_tx_btype <= com_proto_pkg::BTYPE_INIT;
        end else if (state == com_ctrl_pkg::MAIN_IDLE) begin
            com_tx_btype <= com_proto_pkg::BTYPE_INIT;
        end else if (read_start) begin
            com_tx_btype <= com_proto_pkg::BTYPE_INFO;
        end else if (send_start) begin
            com_tx_btype <= com_proto_pkg::BTYPE_DATA;
        end
    end

    // type seen by the user, cleared whenever the controller is idle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com_btype <= com_proto_pkg::BTYPE_INIT;
        end else if (reply || state == com_ctrl_pkg::READ_IDLE) begin
            com_btype <= com_rx_btype;
        end else if (state == com_ctrl_pkg::MAIN_IDLE || state == com_ctrl_pkg::MAIN_WAIT) begin
            com_btype <= com_proto_pkg::BTYPE_INIT;
        end
    end

endmodule

//--- com_ctrl_pkg.sv
package com_ctrl_pkg;

    localparam logic [31:0] TIMEOUT = 32'd1_500;   // reply wait in cycles.
    localparam logic [7:0] NUM_OUT = 8'h03;        // frames per send attempt.
    localparam com_proto_pkg::idx_t DATA_IDX = 4'h5;

    // one-hot, main group then read group then send group.
    typedef enum logic [9:0] {
        MAIN_IDLE = 10'h001,
        MAIN_WAIT = 10'h002,
        READ_IDLE = 10'h004,
        READ_WAIT = 10'h008,
        READ_WORK = 10'h010,
        READ_DONE = 10'h020,
        SEND_IDLE = 10'h040,
        SEND_WAIT = 10'h080,
        SEND_WORK = 10'h100,
        SEND_DONE = 10'h200
    } cs_state_t;

endpackage

//--- com_proto_pkg.sv
package com_proto_pkg;

    typedef logic [7:0] byte_t;   // one link byte.
    typedef logic [3:0] btype_t;
    typedef logic [3:0] idx_t;

    // frame start marker.
    localparam byte_t SYNC = 8'hA5;

    // block types, lower nibble of the second frame byte.
    localparam btype_t BTYPE_INIT = 4'h0;   // no type.
    localparam btype_t BTYPE_INFO = 4'h1;   // reply to a peer request.
    localparam btype_t BTYPE_DATA = 4'hE;   // user data send.

endpackage

//--- com_rx.sv
`timescale 1ns/1ps

module com_rx (
    input  logic                  clk,
    input  logic                  rst,
    input  com_proto_pkg::byte_t  rx_data,
    input  logic                  rx_valid,
    input  logic                  fd_com_read,
    output logic                  fs_com_read,
    output com_proto_pkg::btype_t com_rx_btype
);

    typedef enum logic [1:0] {
        RX_HUNT,
        RX_TYPE,
        RX_HOLD
    } rx_state_t;

    rx_state_t state;
    rx_state_t next_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RX_HUNT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RX_HUNT: begin
                // anything but sync is noise here.
                if (rx_valid && (rx_data == com_proto_pkg::SYNC)) begin
                    next_state = RX_TYPE;
                end
            end
            RX_TYPE: begin
                if (rx_valid) begin
                    next_state = RX_HOLD;
                end
            end
            RX_HOLD: begin
                // bytes arriving now are dropped.
                if (fd_com_read) begin
                    next_state = RX_HUNT;
                end
            end
            default: begin
                next_state = RX_HUNT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if ((state == RX_TYPE) && rx_valid) begin
            com_rx_btype <= rx_data[3:0];   // upper nibble is the peer index.
        end
    end

    assign fs_com_read = (state == RX_HOLD);

endmodule

//--- com_tb.sv
`timescale 1ns/1ps

module com_tb;

    localparam int TIMEOUT_CYCLES = int'(com_ctrl_pkg::TIMEOUT);
    localparam int FRAMES_PER_SEND = int'(com_ctrl_pkg::NUM_OUT);
    localparam int NUM_CASES = 40;
    localparam int CYCLE_LIMIT = NUM_CASES * (3 * TIMEOUT_CYCLES + 200);

    logic                  clk;
    logic                  rst;
    com_proto_pkg::byte_t  rx_data;
    logic                  rx_valid;
    com_proto_pkg::byte_t  tx_data;
    logic                  tx_valid;
    logic                  fs_send;
    logic                  fd_send;
    logic                  fs_read;
    logic                  fd_read;
    com_proto_pkg::idx_t   data_idx;
    com_proto_pkg::btype_t com_btype;

    com_proto_pkg::byte_t frames[$];   // second byte of every tx frame.
    logic                 in_frame;
    com_proto_pkg::idx_t  exp_idx;
    int                   cycle_count = 0;
    int                   value_errors = 0;
    int                   frame_errors = 0;

    com_top dut (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .fs_send   (fs_send),
        .fd_send   (fd_send),
        .fs_read   (fs_read),
        .fd_read   (fd_read),
        .data_idx  (data_idx),
        .com_btype (com_btype)
    );

    always #2 clk = ~clk;

    task automatic value_error(input string msg);
        value_errors++;
        $display("** Error at time %0t: %s", $time, msg);
    endtask

    task automatic count_error(input string msg);
        frame_errors++;
        $display("** Error at time %0t: wrong frame count, %s", $time, msg);
    endtask

    function automatic com_proto_pkg::byte_t frame_byte(input com_proto_pkg::idx_t idx,
                                                        input com_proto_pkg::btype_t btype);
        return {idx, btype};
    endfunction

    function automatic com_proto_pkg::idx_t next_index(input com_proto_pkg::idx_t idx);
        if (idx == 4'd5) return 4'd0;   // wraps after the largest index.
        return idx + 4'd1;
    endfunction

    // pairs each tx sync with the byte after it.
    always @(posedge clk) begin
        if (rst) begin
            in_frame = 1'b0;
        end else if (tx_valid) begin
            if (!in_frame) begin
                if (tx_data != com_proto_pkg::SYNC) begin
                    value_error($sformatf("tx frame starts with %h, not sync", tx_data));
                end
                in_frame = 1'b1;
            end else begin
                frames.push_back(tx_data);
                in_frame = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic strobe_rx(input com_proto_pkg::byte_t b);
        rx_data = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        rx_data = 8'h00;
    endtask

    // one peer frame with random noise and gaps.
    task automatic send_peer_frame(input com_proto_pkg::btype_t btype);
        int                   noise;
        com_proto_pkg::byte_t junk;
        noise = $urandom_range(0, 3);
        repeat (noise) begin
            idle_cycles($urandom_range(0, 3));
            junk = 8'($urandom_range(0, 255));
            if (junk == com_proto_pkg::SYNC) junk = 8'h5A;
            strobe_rx(junk);
        end
        idle_cycles($urandom_range(0, 3));
        strobe_rx(com_proto_pkg::SYNC);
        idle_cycles($urandom_range(0, 3));
        strobe_rx({4'($urandom_range(0, 15)), btype});   // peer index is don't care.
    endtask

    // checks the data frames and the fd_send hold and release.
    task automatic finish_send(input com_proto_pkg::btype_t exp_type);
        com_proto_pkg::byte_t want;
        com_proto_pkg::byte_t got;
        int                   hold;
        want = frame_byte(exp_idx, com_proto_pkg::BTYPE_DATA);
        while (frames.size() > 0) begin
            got = frames.pop_front();
            if (got != want) value_error($sformatf("data frame %h, expected %h", got, want));
        end
        if (data_idx != exp_idx) begin
            value_error($sformatf("data_idx %0d, expected %0d", data_idx, exp_idx));
        end
        hold = $urandom_range(0, 10);
        repeat (hold + 1) begin
            if (!fd_send) value_error("fd_send fell while fs_send high");
            if (com_btype != exp_type) begin
                value_error($sformatf("com_btype %h, expected %h", com_btype, exp_type));
            end
            @(negedge clk);
        end
        fs_send = 1'b0;
        while (fd_send) @(negedge clk);
        @(negedge clk);
        if (com_btype != com_proto_pkg::BTYPE_INIT) value_error("com_btype not cleared in idle");
    endtask

    task automatic replied_send();
        com_proto_pkg::btype_t reply_type;
        int                    delay;
        reply_type = 4'($urandom_range(0, 15));
        delay = $urandom_range(1, TIMEOUT_CYCLES - 300);
        exp_idx = next_index(exp_idx);
        fs_send = 1'b1;
        while (frames.size() == 0) @(negedge clk);
        idle_cycles(delay);
        send_peer_frame(reply_type);
        while (!fd_send) @(negedge clk);
        if (frames.size() != 1) begin
            count_error($sformatf("%0d data frames for a reply", frames.size()));
        end
        finish_send(reply_type);
    endtask

    task automatic unanswered_send();
        exp_idx = next_index(exp_idx);
        fs_send = 1'b1;
        while (!fd_send) @(negedge clk);
        if (frames.size() != FRAMES_PER_SEND) begin
            count_error($sformatf("%0d data frames without reply", frames.size()));
        end
        finish_send(com_proto_pkg::BTYPE_INIT);
    endtask

    task automatic serve_peer_request();
        com_proto_pkg::btype_t req_type;
        com_proto_pkg::byte_t  got;
        com_proto_pkg::byte_t  want;
        req_type = 4'($urandom_range(0, 15));
        want = frame_byte(exp_idx, com_proto_pkg::BTYPE_INFO);
        send_peer_frame(req_type);
        while (!fs_read) @(negedge clk);
        if (com_btype != req_type) begin
            value_error($sformatf("request type %h, expected %h", com_btype, req_type));
        end
        idle_cycles($urandom_range(0, 20));
        if (!fs_read) value_error("fs_read fell before fd_read");
        if (frames.size() != 0) count_error("tx frame before fd_read");
        fd_read = 1'b1;
        while (fs_read) @(negedge clk);
        fd_read = 1'b0;
        while (frames.size() == 0) @(negedge clk);
        got = frames.pop_front();
        if (got != want) value_error($sformatf("info frame %h, expected %h", got, want));
        idle_cycles(2);   // fd_com_send, then back in idle.
        if (com_btype != com_proto_pkg::BTYPE_INIT) value_error("com_btype not cleared after read");
    endtask

    initial begin
        int kind;
        clk = 1'b0;
        rst = 1'b1;
        rx_data = 8'h00;
        rx_valid = 1'b0;
        fs_send = 1'b0;
        fd_read = 1'b0;
        exp_idx = 4'd4;   // index after reset.
        void'($urandom(32'hcb44));
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (fd_send || fs_read || tx_valid) value_error("handshake output high after reset");
        if (com_btype != com_proto_pkg::BTYPE_INIT) value_error("com_btype not 0 after reset");
        for (int i = 0; i < NUM_CASES; i++) begin
            idle_cycles($urandom_range(2, 8));
            if (frames.size() != 0) count_error("extra tx frame between cases");
            frames.delete();
            kind = (i < 3) ? i : $urandom_range(0, 2);   // each kind at least once.
            case (kind)
                0: replied_send();
                1: unanswered_send();
                default: serve_peer_request();
            endcase
        end
        idle_cycles(10);
        $display("errors: %0d value, %0d frame count", value_errors, frame_errors);
        if (value_errors == 0 && frame_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- com_top.sv
`timescale 1ns/1ps

module com_top (
    input  logic                  clk,
    input  logic                  rst,
    input  com_proto_pkg::byte_t  rx_data,
    input  logic                  rx_valid,
    output com_proto_pkg::byte_t  tx_data,
    output logic                  tx_valid,
    input  logic                  fs_send,
    output logic                  fd_send,
    output logic                  fs_read,
    input  logic                  fd_read,
    output com_proto_pkg::idx_t   data_idx,
    output com_proto_pkg::btype_t com_btype
);

    logic                  fs_com_read;
    logic                  fd_com_read;
    logic                  fs_com_send;
    logic                  fd_com_send;
    com_proto_pkg::btype_t com_rx_btype;
    com_proto_pkg::btype_t com_tx_btype;

    com_rx u_rx (
        .clk          (clk),
        .rst          (rst),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .fd_com_read  (fd_com_read),
        .fs_com_read  (fs_com_read),
        .com_rx_btype (com_rx_btype)
    );

    com_cs u_cs (
        .clk          (clk),
        .rst          (rst),
        .fs_send      (fs_send),
        .fd_send      (fd_send),
        .fs_read      (fs_read),
        .fd_read      (fd_read),
        .fs_com_send  (fs_com_send),
        .fd_com_send  (fd_com_send),
        .fs_com_read  (fs_com_read),
        .fd_com_read  (fd_com_read),
        .com_tx_btype (com_tx_btype),
        .com_rx_btype (com_rx_btype),
        .data_idx     (data_idx),
        .com_btype    (com_btype)
    );

    com_tx u_tx (
        .clk          (clk),
        .rst          (rst),
        .fs_com_send  (fs_com_send),
        .com_tx_btype (com_tx_btype),
        .data_idx     (data_idx),
        .fd_com_send  (fd_com_send),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid)
    );

endmodule

//--- com_tx.sv
`timescale 1ns/1ps

module com_tx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fs_com_send,
    input  com_proto_pkg::btype_t com_tx_btype,
    input  com_proto_pkg::idx_t   data_idx,
    output logic                  fd_com_send,
    output com_proto_pkg::byte_t  tx_data,
    output logic                  tx_valid
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SYNC,
        TX_TYPE,
        TX_DONE
    } tx_state_t;

    tx_state_t state;
    tx_state_t next_state;

    com_proto_pkg::btype_t btype_q;
    com_proto_pkg::idx_t   idx_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= TX_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            TX_IDLE: begin
                if (fs_com_send) next_state = TX_SYNC;
            end
            TX_SYNC: next_state = TX_TYPE;
            TX_TYPE: next_state = TX_DONE;
            TX_DONE: next_state = TX_IDLE;
            default: next_state = TX_IDLE;
        endcase
    end

    // frame contents are fixed for the whole frame.
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && fs_com_send) begin
            btype_q <= com_tx_btype;
            idx_q <= data_idx;
        end
    end

    always_comb begin
        tx_data = 8'h00;
        tx_valid = 1'b0;
        case (state)
            TX_SYNC: begin
                tx_data = com_proto_pkg::SYNC;
                tx_valid = 1'b1;
            end
            TX_TYPE: begin
                tx_data = {idx_q, btype_q};   // index high, type low.
                tx_valid = 1'b1;
            end
            default: ;
        endcase
    end

    assign fd_com_send = (state == TX_DONE);

endmodule

//--- vlog.f
com_proto_pkg.sv
com_ctrl_pkg.sv
com_rx.sv
com_cs.sv
com_tx.sv
com_top.sv
com_tb.sv
